//--- sources.f
logic/reflex_pkg.sv
logic/param_bank.sv
logic/synapse_current.sv
logic/drive_mixer.sv
logic/spike_window_counter.sv
logic/reflex_top.sv
tests/reflex_tb.sv

//--- run_sim.sh
#!/bin/sh
# build the reflex testbench with verilator, run it, look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f sources.f --top-module reflex_tb -o reflex_sim \
    && ./obj_dir/reflex_sim | tee /dev/stderr | grep -qx "No errors" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

//--- tests/reflex_tb.sv
`timescale 1ns/1ps

module reflex_tb
    import reflex_pkg::*;
();

    ////////////////////////////////////////////////////////////////////////////
    // setup
    ////////////////////////////////////////////////////////////////////////////

    localparam word_t       EPSC_STEP    = 32'd1024;
    localparam int unsigned DECAY_SHIFT  = 3;
    localparam int unsigned COUNT_WINDOW = 16;
    localparam int          RESET_CYCLES = 16;

    // one table row held for hold cycles
    typedef struct packed {
        int          test;
        logic        rst;
        trig_t       trig;
        host_wires_t wires;
        spike_set_t  spikes;
        logic        rnd;
        int          hold;
        logic        chk;
        word_t       exp_cn;
        word_t       exp_cn2;
        word_t       exp_mn;
    } row_t;

    localparam spike_set_t SPK_NONE  = 5'b00000;
    localparam spike_set_t SPK_SN_IA = 5'b10000;
    // every synapse input, no mn pulse
    localparam spike_set_t SPK_SYN   = 5'b11110;

    logic          ep50trig;
    logic          reset_sim;
    trig_t         trig;
    host_wires_t   wires;
    spike_set_t    spikes;
    drive_set_t    drives;
    spike_counts_t counts;

    row_t        rows[$];
    logic [31:0] lfsr_state = 32'h9468808f;
    int          checks;
    int          errors;
    int          cycle_count;
    int          cycle_limit;

    reflex_top #(
        .EPSC_STEP    (EPSC_STEP),
        .DECAY_SHIFT  (DECAY_SHIFT),
        .COUNT_WINDOW (COUNT_WINDOW)
    ) i_dut (
        .i_clk    (ep50trig),
        .i_rst    (reset_sim),
        .i_trig   (trig),
        .i_wires  (wires),
        .i_spikes (spikes),
        .o_drives (drives),
        .o_counts (counts)
    );

    // 40 ns period
    initial
    begin
        ep50trig = 1'b0;
        forever #20 ep50trig = ~ep50trig;
    end

    ////////////////////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////////////////////

    task automatic check_word(input word_t got, input word_t exp, input string what);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("FAIL %0t: %s got %08h expected %08h", $time, what, got, exp);
        end
    endtask

    // fibonacci lfsr with taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // one lfsr step per spike bit
    task automatic draw_spikes(output spike_set_t sp);
        logic [4:0] bits;
        for (int i = 0; i < 5; i++)
        begin
            lfsr_state = lfsr_next(lfsr_state);
            bits[i] = lfsr_state[0];
        end
        sp = spike_set_t'(bits);
    endtask

    // high half on the even wire
    function automatic host_wires_t make_wires(input word_t single, input word_t m1_cn,
                                               input word_t m1_cn2);
        host_wires_t w;
        w.wire_01 = single[15:0];
        w.wire_02 = single[31:16];
        w.wire_05 = m1_cn[15:0];
        w.wire_06 = m1_cn[31:16];
        w.wire_07 = m1_cn2[15:0];
        w.wire_08 = m1_cn2[31:16];
        return w;
    endfunction

    function automatic trig_t trig_bit(input int unsigned idx);
        trig_t t;
        t = '0;
        t[idx] = 1'b1;
        return t;
    endfunction

    function automatic string test_name(input int n);
        case (n)
            1:       return "reset and default gains";
            2:       return "gain and m1 loads";
            3:       return "single ia pulse";
            4:       return "random spikes";
            default: return "window counts";
        endcase
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // table building
    ////////////////////////////////////////////////////////////////////////////

    task automatic add_row(input int test, input logic rst_bit, input trig_t t,
                           input host_wires_t w, input spike_set_t sp, input logic rnd,
                           input int hold, input logic chk, input word_t e_cn,
                           input word_t e_cn2, input word_t e_mn);
        row_t row;
        row = '{test, rst_bit, t, w, sp, rnd, hold, chk, e_cn, e_cn2, e_mn};
        rows.push_back(row);
    endtask

    task automatic idle_row(input int test, input int hold);
        add_row(test, 1'b0, '0, '0, SPK_NONE, 1'b0, hold, 1'b0, '0, '0, '0);
    endtask

    task automatic reset_row(input int test, input int hold);
        add_row(test, 1'b1, '0, '0, SPK_NONE, 1'b0, hold, 1'b0, '0, '0, '0);
    endtask

    task automatic load_row(input int test, input trig_t t, input host_wires_t w);
        add_row(test, 1'b0, t, w, SPK_NONE, 1'b0, 1, 1'b0, '0, '0, '0);
    endtask

    task automatic pulse_row(input int test, input spike_set_t sp);
        add_row(test, 1'b0, '0, '0, sp, 1'b0, 1, 1'b0, '0, '0, '0);
    endtask

    task automatic random_row(input int test, input int hold);
        add_row(test, 1'b0, '0, '0, SPK_NONE, 1'b1, hold, 1'b0, '0, '0, '0);
    endtask

    // idle cycle that checks the drives at its end
    task automatic check_row(input int test, input word_t e_cn, input word_t e_cn2,
                             input word_t e_mn);
        add_row(test, 1'b0, '0, '0, SPK_NONE, 1'b0, 1, 1'b1, e_cn, e_cn2, e_mn);
    endtask

    task automatic build_table();
        // drives zero after reset then unity gains on the first spike
        check_row(1, 0, 0, 0);
        idle_row(1, 3);
        pulse_row(1, SPK_SN_IA);
        idle_row(1, 1);
        check_row(1, 1024, 1024, 1024);
        check_row(1, 896, 896, 896);
        // every gain and both m1 drives
        reset_row(2, 2);
        load_row(2, trig_bit(TRIG_GAIN_SN_MN), make_wires(32'd5, 0, 0));
        load_row(2, trig_bit(TRIG_GAIN_CN_MN), make_wires(32'd7, 0, 0));
        load_row(2, trig_bit(TRIG_GAIN_CN2_MN), make_wires(32'd11, 0, 0));
        load_row(2, trig_bit(TRIG_GAIN_SN_CN), make_wires(32'd13, 0, 0));
        load_row(2, trig_bit(TRIG_M1_DRIVE), make_wires(32'hffffffff, 32'h12345678,
                                                        32'h0badf00d));
        idle_row(2, 1);
        check_row(2, 32'h12345678, 32'h0badf00d, 0);
        // bits with no parameter behind them
        load_row(2, 16'he9b7, make_wires(32'd99, 32'd99, 32'd99));
        // every synapse fires so a stray gain load shows up
        pulse_row(2, SPK_SYN);
        idle_row(2, 1);
        check_row(2, 32'h12345678 + 13 * 1024, 32'h0badf00d + 13 * 1024,
                  (5 + 5 + 7 + 11) * 1024);
        // 1024 x gain then one eighth less each cycle
        reset_row(3, 2);
        load_row(3, trig_bit(TRIG_GAIN_SN_MN), make_wires(32'd3, 0, 0));
        load_row(3, trig_bit(TRIG_GAIN_SN_CN), make_wires(32'd2, 0, 0));
        pulse_row(3, SPK_SN_IA);
        idle_row(3, 1);
        check_row(3, 2048, 2048, 3 * 1024);
        check_row(3, 1792, 1792, 3 * 896);
        check_row(3, 1568, 1568, 3 * 784);
        // large gains so the products wrap
        load_row(4, trig_bit(TRIG_GAIN_SN_MN), make_wires(32'h00030001, 0, 0));
        load_row(4, trig_bit(TRIG_GAIN_CN_MN), make_wires(32'h7fff0005, 0, 0));
        load_row(4, trig_bit(TRIG_GAIN_CN2_MN), make_wires(32'd250000, 0, 0));
        load_row(4, trig_bit(TRIG_M1_DRIVE), make_wires(0, 32'hfff00000, 32'h00c0ffee));
        random_row(4, 96);
        // windows aligned to a fresh reset
        reset_row(5, 2);
        random_row(5, 64);
        idle_row(5, 20);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // reference model
    ////////////////////////////////////////////////////////////////////////////

    word_t         m_gain_sn_mn;
    word_t         m_gain_cn_mn;
    word_t         m_gain_cn2_mn;
    word_t         m_gain_sn_cn;
    word_t         m_m1_cn;
    word_t         m_m1_cn2;
    word_t         m_cur_ia;
    word_t         m_cur_ii;
    word_t         m_cur_cn;
    word_t         m_cur_cn2;
    word_t         m_cur_sn_cn;
    drive_set_t    m_drives;
    spike_counts_t m_counts;
    word_t         m_win_ia;
    word_t         m_win_mn;
    int unsigned   m_pos;

    // leak by 2^-DECAY_SHIFT plus a fixed step per spike
    function automatic word_t next_current(input word_t cur, input logic spike);
        word_t leak;
        leak = cur >> DECAY_SHIFT;
        return cur - leak + (spike ? EPSC_STEP : 32'd0);
    endfunction

    always @(posedge ep50trig or posedge reset_sim)
    begin
        if (reset_sim)
        begin
            m_gain_sn_mn  = 32'd1;
            m_gain_cn_mn  = 32'd1;
            m_gain_cn2_mn = 32'd1;
            m_gain_sn_cn  = 32'd1;
            m_m1_cn       = '0;
            m_m1_cn2      = '0;
            m_cur_ia      = '0;
            m_cur_ii      = '0;
            m_cur_cn      = '0;
            m_cur_cn2     = '0;
            m_cur_sn_cn   = '0;
            m_drives      = '0;
            m_counts      = '0;
            m_win_ia      = '0;
            m_win_mn      = '0;
            m_pos         = 0;
        end
        else
        begin
            // drives latch currents and params from before this edge
            m_drives.drive_mn  = m_cur_ia * m_gain_sn_mn + m_cur_ii * m_gain_sn_mn
                               + m_cur_cn * m_gain_cn_mn + m_cur_cn2 * m_gain_cn2_mn;
            m_drives.drive_cn  = m_cur_sn_cn * m_gain_sn_cn + m_m1_cn;
            m_drives.drive_cn2 = m_cur_sn_cn * m_gain_sn_cn + m_m1_cn2;
            m_cur_ia    = next_current(m_cur_ia, spikes.sn_ia);
            m_cur_ii    = next_current(m_cur_ii, spikes.sn_ii);
            m_cur_cn    = next_current(m_cur_cn, spikes.cn);
            m_cur_cn2   = next_current(m_cur_cn2, spikes.cn2);
            m_cur_sn_cn = next_current(m_cur_sn_cn, spikes.sn_ia);
            // parameter loads with the upper half on the even wire
            if (trig[TRIG_GAIN_SN_MN])
                m_gain_sn_mn = {wires.wire_02, wires.wire_01};
            if (trig[TRIG_GAIN_CN_MN])
                m_gain_cn_mn = {wires.wire_02, wires.wire_01};
            if (trig[TRIG_GAIN_CN2_MN])
                m_gain_cn2_mn = {wires.wire_02, wires.wire_01};
            if (trig[TRIG_GAIN_SN_CN])
                m_gain_sn_cn = {wires.wire_02, wires.wire_01};
            if (trig[TRIG_M1_DRIVE])
            begin
                m_m1_cn  = {wires.wire_06, wires.wire_05};
                m_m1_cn2 = {wires.wire_08, wires.wire_07};
            end
            // window totals include the last cycle's pulse
            m_win_ia = m_win_ia + word_t'(spikes.sn_ia);
            m_win_mn = m_win_mn + word_t'(spikes.mn);
            m_pos    = m_pos + 1;
            if (m_pos == COUNT_WINDOW)
            begin
                m_counts.count_sn_ia = m_win_ia;
                m_counts.count_mn    = m_win_mn;
                m_win_ia = '0;
                m_win_mn = '0;
                m_pos    = 0;
            end
        end
    end

    task automatic compare_model();
        check_word(drives.drive_cn, m_drives.drive_cn, "drive_cn vs model");
        check_word(drives.drive_cn2, m_drives.drive_cn2, "drive_cn2 vs model");
        check_word(drives.drive_mn, m_drives.drive_mn, "drive_mn vs model");
        check_word(counts.count_sn_ia, m_counts.count_sn_ia, "count_sn_ia vs model");
        check_word(counts.count_mn, m_counts.count_mn, "count_mn vs model");
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // watchdog
    ////////////////////////////////////////////////////////////////////////////

    always @(posedge ep50trig)
    begin
        cycle_count++;
        if (cycle_count > cycle_limit)
        begin
            $display("timeout: run still going after %0d clock cycles", cycle_count);
            $display("Errors found");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////////////////////

    initial
    begin
        row_t       row;
        spike_set_t spk;
        int         test_checks;
        int         test_errors;
        int         n_tests;
        int         total;
        reset_sim <= 1'b1;
        trig      <= '0;
        wires     <= '0;
        spikes    <= '0;
        build_table();
        total = 0;
        foreach (rows[i])
            total += rows[i].hold;
        cycle_limit = RESET_CYCLES + total + 64;
        repeat (RESET_CYCLES)
        begin
            @(posedge ep50trig);
            @(negedge ep50trig);
            compare_model();
        end
        n_tests = 0;
        test_checks = checks;
        test_errors = errors;
        for (int r = 0; r < rows.size(); r++)
        begin
            row = rows[r];
            for (int c = 0; c < row.hold; c++)
            begin
                @(posedge ep50trig);
                if (row.rnd)
                    draw_spikes(spk);
                else
                    spk = row.spikes;
                reset_sim <= row.rst;
                trig      <= row.trig;
                wires     <= row.wires;
                spikes    <= spk;
                @(negedge ep50trig);
                compare_model();
            end
            if (row.chk)
            begin
                check_word(drives.drive_cn, row.exp_cn, $sformatf("row %0d drive_cn", r));
                check_word(drives.drive_cn2, row.exp_cn2, $sformatf("row %0d drive_cn2", r));
                check_word(drives.drive_mn, row.exp_mn, $sformatf("row %0d drive_mn", r));
            end
            // test ends where the next row starts another
            if (r == rows.size() - 1 || rows[r + 1].test != row.test)
            begin
                n_tests++;
                $display("test %0d %s: %0d checks, %0d mismatches", row.test,
                         test_name(row.test), checks - test_checks, errors - test_errors);
                test_checks = checks;
                test_errors = errors;
            end
        end
        $display("%0d tests, %0d checks, %0d mismatches", n_tests, checks, errors);
        if (errors == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule

//--- logic/reflex_top.sv
`timescale 1ns/1ps

module reflex_top
    import reflex_pkg::*;
#(
    parameter word_t       EPSC_STEP    = 32'd1024,
    parameter int unsigned DECAY_SHIFT  = 3,
    parameter int unsigned COUNT_WINDOW = 16
)
(
    // ep50trig
    input  logic          i_clk,
    // reset_sim
    input  logic          i_rst,
    input  trig_t         i_trig,
    input  host_wires_t   i_wires,
    input  spike_set_t    i_spikes,
    output drive_set_t    o_drives,
    output spike_counts_t o_counts
);

    ////////////////////////////////////////////////////////////////////////////
    // host parameters
    ////////////////////////////////////////////////////////////////////////////

    reflex_params_t params;

    param_bank u_param_bank (
        .i_clk    (i_clk),
        .i_rst    (i_rst),
        .i_trig   (i_trig),
        .i_wires  (i_wires),
        .o_params (params)
    );

    ////////////////////////////////////////////////////////////////////////////
    // synapses
    ////////////////////////////////////////////////////////////////////////////

    // scaled currents into the mixer
    word_t syn_sn_mn;
    word_t syn_sn2_mn;
    word_t syn_cn_mn;
    word_t syn_cn2_mn;
    word_t syn_sn_cn;

    // ia afferents straight onto mn
    synapse_current #(.EPSC_STEP(EPSC_STEP), .DECAY_SHIFT(DECAY_SHIFT)) u_syn_sn_mn (
        .i_clk     (i_clk),
        .i_rst     (i_rst),
        .i_spike   (i_spikes.sn_ia),
        .i_gain    (params.gain_sn_mn),
        .o_current (syn_sn_mn)
    );

    // ii afferents share the sensory gain
    synapse_current #(.EPSC_STEP(EPSC_STEP), .DECAY_SHIFT(DECAY_SHIFT)) u_syn_sn2_mn (
        .i_clk     (i_clk),
        .i_rst     (i_rst),
        .i_spike   (i_spikes.sn_ii),
        .i_gain    (params.gain_sn_mn),
        .o_current (syn_sn2_mn)
    );

    // transcortical loop back onto mn
    synapse_current #(.EPSC_STEP(EPSC_STEP), .DECAY_SHIFT(DECAY_SHIFT)) u_syn_cn_mn (
        .i_clk     (i_clk),
        .i_rst     (i_rst),
        .i_spike   (i_spikes.cn),
        .i_gain    (params.gain_cn_mn),
        .o_current (syn_cn_mn)
    );

    synapse_current #(.EPSC_STEP(EPSC_STEP), .DECAY_SHIFT(DECAY_SHIFT)) u_syn_cn2_mn (
        .i_clk     (i_clk),
        .i_rst     (i_rst),
        .i_spike   (i_spikes.cn2),
        .i_gain    (params.gain_cn2_mn),
        .o_current (syn_cn2_mn)
    );

    // ia onto cortex
    // same spike and gain for cn and cn2 so one instance serves both
    synapse_current #(.EPSC_STEP(EPSC_STEP), .DECAY_SHIFT(DECAY_SHIFT)) u_syn_sn_cn (
        .i_clk     (i_clk),
        .i_rst     (i_rst),
        .i_spike   (i_spikes.sn_ia),
        .i_gain    (params.gain_sn_cn),
        .o_current (syn_sn_cn)
    );

    ////////////////////////////////////////////////////////////////////////////
    // drives and counters
    ////////////////////////////////////////////////////////////////////////////

    drive_mixer u_drive_mixer (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_syn_sn_mn  (syn_sn_mn),
        .i_syn_sn2_mn (syn_sn2_mn),
        .i_syn_cn_mn  (syn_cn_mn),
        .i_syn_cn2_mn (syn_cn2_mn),
        .i_syn_sn_cn  (syn_sn_cn),
        .i_params     (params),
        .o_drives     (o_drives)
    );

    // windowed totals
    word_t count_sn_ia;
    word_t count_mn;

    spike_window_counter #(.COUNT_WINDOW(COUNT_WINDOW)) u_cnt_sn_ia (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_spike (i_spikes.sn_ia),
        .o_count (count_sn_ia)
    );

    spike_window_counter #(.COUNT_WINDOW(COUNT_WINDOW)) u_cnt_mn (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_spike (i_spikes.mn),
        .o_count (count_mn)
    );

    assign o_counts = '{count_sn_ia: count_sn_ia, count_mn: count_mn};

endmodule

//--- logic/spike_window_counter.sv
`timescale 1ns/1ps

module spike_window_counter
    import reflex_pkg::*;
#(
    // window length in clock cycles
    parameter int unsigned COUNT_WINDOW = 16
)
(
    input  logic  i_clk,
    input  logic  i_rst,
    input  logic  i_spike,
    output word_t o_count
);

    // cycle counter width, at least one bit
    localparam int unsigned CW = (COUNT_WINDOW > 1) ? $clog2(COUNT_WINDOW) : 1;
    localparam logic [CW-1:0] LAST_CYCLE = CW'(COUNT_WINDOW - 1);

    // position inside the window
    logic [CW-1:0] cycle_q;

    // spikes so far in this window
    word_t acc_q;

    // held total of the last full window
    word_t count_q;

    // running total including this cycle
    word_t acc_next;

    assign acc_next = acc_q + word_t'(i_spike);

    always_ff @(posedge i_clk or posedge i_rst)
    begin
        if (i_rst)
        begin
            cycle_q <= '0;
            acc_q   <= '0;
            count_q <= '0;
        end
        else if (cycle_q == LAST_CYCLE)
        begin
            // window closes
            // publish and restart
            cycle_q <= '0;
            acc_q   <= '0;
            count_q <= acc_next;
        end
        else
        begin
            cycle_q <= cycle_q + 1'b1;
            acc_q   <= acc_next;
        end
    end

    assign o_count = count_q;

endmodule

//--- logic/drive_mixer.sv
`timescale 1ns/1ps

module drive_mixer
    import reflex_pkg::*;
(
    input  logic           i_clk,
    input  logic           i_rst,
    // sensory ia onto mn
    input  word_t          i_syn_sn_mn,
    // sensory ii onto mn
    input  word_t          i_syn_sn2_mn,
    // cortical pools onto mn
    input  word_t          i_syn_cn_mn,
    input  word_t          i_syn_cn2_mn,
    // sensory onto both cortical pools
    input  word_t          i_syn_sn_cn,
    input  reflex_params_t i_params,
    output drive_set_t     o_drives
);

    ////////////////////////////////////////////////////////////////////////////
    // current sums
    ////////////////////////////////////////////////////////////////////////////

    // unlatched sums
    word_t sum_mn;
    word_t sum_cn;
    word_t sum_cn2;

    // latched drives
    drive_set_t drives_q;

    // spinal and transcortical paths meet at the mn
    // all sums wrap at 32 bits
    assign sum_mn = i_syn_sn_mn + i_syn_sn2_mn + i_syn_cn_mn + i_syn_cn2_mn;

    // one shared sensory current feeds both cortical pools
    // voluntary command added on top
    assign sum_cn  = i_syn_sn_cn + i_params.m1_cn_drive;
    assign sum_cn2 = i_syn_sn_cn + i_params.m1_cn2_drive;

    ////////////////////////////////////////////////////////////////////////////
    // latch
    ////////////////////////////////////////////////////////////////////////////

    // one register stage after the synapse current
    // spike at edge n shows here at edge n+2
    always_ff @(posedge i_clk or posedge i_rst)
    begin
        if (i_rst)
        begin
            drives_q.drive_cn  <= '0;
            drives_q.drive_cn2 <= '0;
            drives_q.drive_mn  <= '0;
        end
        else
        begin
            drives_q.drive_cn  <= sum_cn;
            drives_q.drive_cn2 <= sum_cn2;
            drives_q.drive_mn  <= sum_mn;
        end
    end

    assign o_drives = drives_q;

endmodule

//--- logic/synapse_current.sv
`timescale 1ns/1ps

module synapse_current
    import reflex_pkg::*;
#(
    // current added per presynaptic spike
    parameter word_t       EPSC_STEP   = 32'd1024,
    // decay of 2^-DECAY_SHIFT per cycle
    parameter int unsigned DECAY_SHIFT = 3
)
(
    input  logic  i_clk,
    input  logic  i_rst,
    input  logic  i_spike,
    input  word_t i_gain,
    output word_t o_current
);

    ////////////////////////////////////////////////////////////////////////////
    // postsynaptic current
    ////////////////////////////////////////////////////////////////////////////

    // unscaled current register
    word_t current_q;

    // next state pieces
    word_t decay_amt;
    word_t epsc_add;
    word_t current_d;

    // exponential leak by shift
    assign decay_amt = current_q >> DECAY_SHIFT;

    // fixed step per spike
    assign epsc_add = i_spike ? EPSC_STEP : '0;

    assign current_d = current_q - decay_amt + epsc_add;

    always_ff @(posedge i_clk or posedge i_rst)
    begin
        if (i_rst)
        begin
            current_q <= '0;
        end
        else
        begin
            current_q <= current_d;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // gain scaling
    ////////////////////////////////////////////////////////////////////////////

    // unsigned multiply
    // only the low 32 bits of the product are kept
    assign o_current = current_q * i_gain;

endmodule

//--- logic/param_bank.sv
`timescale 1ns/1ps

module param_bank
    import reflex_pkg::*;
(
    input  logic           i_clk,
    input  logic           i_rst,
    input  trig_t          i_trig,
    input  host_wires_t    i_wires,
    output reflex_params_t o_params
);

    ////////////////////////////////////////////////////////////////////////////
    // wire pairs
    ////////////////////////////////////////////////////////////////////////////

    // single word load from wire 02 and 01
    word_t single_word;

    // motor cortex drives from wires 05 to 08
    word_t m1_cn_word;
    word_t m1_cn2_word;

    // parameter registers
    reflex_params_t params_q;

    // high half on the even wire
    assign single_word = {i_wires.wire_02, i_wires.wire_01};
    assign m1_cn_word  = {i_wires.wire_06, i_wires.wire_05};
    assign m1_cn2_word = {i_wires.wire_08, i_wires.wire_07};

    ////////////////////////////////////////////////////////////////////////////
    // trigger loads
    ////////////////////////////////////////////////////////////////////////////

    // each trigger bit is a level enable on this clock
    // unused trigger bits fall through with no effect
    always_ff @(posedge i_clk or posedge i_rst)
    begin
        if (i_rst)
        begin
            // unity gains
            params_q.gain_sn_mn   <= DEFAULT_GAIN;
            params_q.gain_cn_mn   <= DEFAULT_GAIN;
            params_q.gain_cn2_mn  <= DEFAULT_GAIN;
            params_q.gain_sn_cn   <= DEFAULT_GAIN;
            // no voluntary drive
            params_q.m1_cn_drive  <= DEFAULT_M1_DRIVE;
            params_q.m1_cn2_drive <= DEFAULT_M1_DRIVE;
        end
        else
        begin
            // cortical synapse gain onto mn
            if (i_trig[TRIG_GAIN_CN_MN])
            begin
                params_q.gain_cn_mn <= single_word;
            end
            // sensory synapse gain onto mn
            if (i_trig[TRIG_GAIN_SN_MN])
            begin
                params_q.gain_sn_mn <= single_word;
            end
            // second cortical pool onto mn
            if (i_trig[TRIG_GAIN_CN2_MN])
            begin
                params_q.gain_cn2_mn <= single_word;
            end
            // both m1 drives load together
            if (i_trig[TRIG_M1_DRIVE])
            begin
                params_q.m1_cn_drive  <= m1_cn_word;
                params_q.m1_cn2_drive <= m1_cn2_word;
            end
            // sensory gain into both cortical pools
            if (i_trig[TRIG_GAIN_SN_CN])
            begin
                params_q.gain_sn_cn <= single_word;
            end
        end
    end

    // new value visible the cycle after its trigger
    assign o_params = params_q;

endmodule

//--- logic/reflex_pkg.sv
package reflex_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // basic words
    ////////////////////////////////////////////////////////////////////////////

    // currents, gains and spike counts
    typedef logic [31:0] word_t;

    // one host wire endpoint
    typedef logic [15:0] half_word_t;

    // host trigger endpoint bits
    typedef logic [15:0] trig_t;

    ////////////////////////////////////////////////////////////////////////////
    // bundles
    ////////////////////////////////////////////////////////////////////////////

    // host wire words, low half before high half in each pair
    typedef struct packed {
        half_word_t wire_01;
        half_word_t wire_02;
        half_word_t wire_05;
        half_word_t wire_06;
        half_word_t wire_07;
        half_word_t wire_08;
    } host_wires_t;

    // host loaded reflex parameters
    typedef struct packed {
        word_t gain_sn_mn;
        word_t gain_cn_mn;
        word_t gain_cn2_mn;
        word_t gain_sn_cn;
        word_t m1_cn_drive;
        word_t m1_cn2_drive;
    } reflex_params_t;

    // one cycle spike pulses from the external neuron pools
    typedef struct packed {
        logic sn_ia;
        logic sn_ii;
        logic cn;
        logic cn2;
        logic mn;
    } spike_set_t;

    // latched drive currents into the neuron pools
    typedef struct packed {
        word_t drive_cn;
        word_t drive_cn2;
        word_t drive_mn;
    } drive_set_t;

    // windowed spike totals
    typedef struct packed {
        word_t count_sn_ia;
        word_t count_mn;
    } spike_counts_t;

    // trigger bit positions on the host trigger endpoint
    localparam int unsigned TRIG_GAIN_CN_MN  = 3;
    localparam int unsigned TRIG_GAIN_SN_MN  = 6;
    localparam int unsigned TRIG_GAIN_CN2_MN = 9;
    localparam int unsigned TRIG_M1_DRIVE    = 10;
    localparam int unsigned TRIG_GAIN_SN_CN  = 12;

    // values loaded by reset_sim
    localparam word_t DEFAULT_GAIN     = 32'd1;
    localparam word_t DEFAULT_M1_DRIVE = 32'd0;

endpackage
